/* list.f */
+incdir+verilog
verilog/cache_pkg.sv
verilog/cpu_port.sv
verilog/cache_datapath.sv
verilog/cache_control.sv
verilog/mem_port.sv
verilog/cache.sv
verif/cache_tb.sv

/* verif/cache_tb.sv */
`include "cache_config.svh"

module cache_tb import cache_pkg::*; ();

    localparam int          NUM_OPS    = 600;
    localparam int          MAX_CYCLES = NUM_OPS * 40;  // A full miss is far below 40 cycles
    localparam logic [15:0] SEED       = 16'd57782;

    logic      clk, arst_n;
    logic      cpu_cyc, cpu_stb, cpu_we, cpu_ack;
    addr_t     cpu_adr;
    word_t     cpu_dat_w, cpu_dat_r;
    byte_sel_t cpu_sel;
    logic      mem_cyc, mem_stb, mem_we, mem_ack;
    addr_t     mem_adr;
    line_t     mem_dat_w, mem_dat_r;

    // ******************************
    // Models and bookkeeping
    // ******************************
    logic [7:0]  model_mem [0:65535];   // Takes every CPU write at once
    logic [7:0]  bus_mem   [0:65535];   // What the memory bus really holds
    tag_t        sh_tag    [2][`CACHE_SETS];
    logic        sh_valid  [2][`CACHE_SETS];
    logic        sh_dirty  [2][`CACHE_SETS];
    logic        sh_lru    [`CACHE_SETS];
    logic [15:0] stim_lfsr, resp_lfsr;
    addr_t       exp_wb_adr, exp_fill_adr, held_adr;
    line_t       held_dat;
    logic        resp_busy;
    int          resp_wait, wr_seen, rd_seen, cycle_cnt;

    cache u_cache (.*);

    always #20 clk = ~clk;

    // Galois LFSR, taps for a maximal 16-bit sequence
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic draw(inout logic [15:0] st, input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | st[0];
            st  = lfsr_step(st);
        end
    endtask

    function automatic logic [7:0] init_byte(input addr_t a);
        return a[7:0] ^ a[15:8] ^ {a[3:0], a[11:8]} ^ 8'hA5;  // Every address bit counts
    endfunction

    function automatic line_t read_line(input addr_t a, input logic from_bus);
        line_t l;
        for (int k = 0; k < `CACHE_LINE_W/8; k++)
            l[k*8 +: 8] = from_bus ? bus_mem[a + k] : model_mem[a + k];
        return l;
    endfunction

    // ******************************
    // Compare tasks
    // ******************************
    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("error: at %0t %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("error: at %0t %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("error: at %0t %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("error: at %0t %s is %0d, expected %0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    // ******************************
    // Memory responder
    // ******************************
    always @(posedge clk) begin
        if (mem_ack) begin
            mem_ack <= 1'b0;                        // Single beat per cycle
        end else if (mem_cyc && mem_stb) begin
            if (!resp_busy) begin
                resp_busy = 1'b1;
                draw(resp_lfsr, 2, resp_wait);      // 0 to 3 cycles of back-pressure
                held_adr = mem_adr;
                held_dat = mem_dat_w;
            end
            check_addr("mem_adr", mem_adr, held_adr);       // Stable until ack
            check_line("mem_dat_w", mem_dat_w, held_dat);
            if (resp_wait == 0) begin
                resp_busy = 1'b0;
                mem_ack <= 1'b1;
                if (mem_we) begin
                    wr_seen++;
                    check_addr("mem_adr", mem_adr, exp_wb_adr);
                    check_line("mem_dat_w", mem_dat_w, read_line(mem_adr, 1'b0));
                    for (int k = 0; k < `CACHE_LINE_W/8; k++)
                        bus_mem[mem_adr + k] = mem_dat_w[k*8 +: 8];
                end else begin
                    rd_seen++;
                    check_addr("mem_adr", mem_adr, exp_fill_adr);
                    mem_dat_r <= read_line(mem_adr, 1'b1);
                end
            end else begin
                resp_wait--;
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: no end after %0d cycles, controller in state %s",
                     cycle_cnt, u_cache.u_cache_control.state.name());
            stop_run();
        end
    end

    // ******************************
    // One CPU request, called on a rising edge
    // ******************************
    task automatic run_op();
        int        r, set_i, t, w, cycles;
        logic      we, hit_pred, hit_way, victim, wb_pred;
        byte_sel_t sel;
        word_t     wdata, mask;
        tag_t      tag;
        addr_t     a;
        draw(stim_lfsr, 1, r);
        we = r[0];
        draw(stim_lfsr, 3, set_i);
        draw(stim_lfsr, 2, t);                      // Four tags per set, many evictions
        draw(stim_lfsr, 3, w);
        draw(stim_lfsr, 2, r);
        sel = (r == 0) ? 2'b11 : r[1:0];
        draw(stim_lfsr, 16, r);
        wdata = r[15:0];
        tag   = tag_t'(37 + t * 131);
        a     = {tag, index_t'(set_i), w[2:0], 1'b0};

        // Prediction from the shadow arrays
        hit_pred = 1'b0;
        hit_way  = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (sh_valid[i][set_i] && sh_tag[i][set_i] == tag) begin
                hit_pred = 1'b1;
                hit_way  = i[0];
            end
        end
        victim       = sh_lru[set_i];
        wb_pred      = !hit_pred && sh_valid[victim][set_i] && sh_dirty[victim][set_i];
        exp_wb_adr   = {sh_tag[victim][set_i], index_t'(set_i), 4'b0};
        exp_fill_adr = {tag, index_t'(set_i), 4'b0};
        wr_seen      = 0;
        rd_seen      = 0;

        cpu_cyc   <= 1'b1;
        cpu_stb   <= 1'b1;
        cpu_we    <= we;
        cpu_adr   <= a;
        cpu_dat_w <= wdata;
        cpu_sel   <= sel;
        cycles = 0;
        @(posedge clk);
        while (!cpu_ack) begin
            cycles++;
            @(posedge clk);
        end

        if (!we) begin
            mask = {{8{sel[1]}}, {8{sel[0]}}};
            check_word("cpu_dat_r", cpu_dat_r & mask, {model_mem[a + 1], model_mem[a]} & mask);
        end
        if (hit_pred)
            check_count("hit latency", cycles, 3);
        check_count("memory writes", wr_seen, int'(wb_pred));
        check_count("memory reads", rd_seen, int'(!hit_pred));
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
        cpu_we  <= 1'b0;

        // Model update after the ack
        if (we) begin
            for (int b = 0; b < 2; b++)
                if (sel[b])
                    model_mem[a + b] = wdata[b*8 +: 8];
        end
        if (!hit_pred) begin
            sh_tag[victim][set_i]   = tag;
            sh_valid[victim][set_i] = 1'b1;
            sh_dirty[victim][set_i] = 1'b0;
            hit_way = victim;
        end
        sh_lru[set_i] = ~hit_way;
        if (we)
            sh_dirty[hit_way][set_i] = 1'b1;

        @(posedge clk);
        check_count("cpu_ack", int'(cpu_ack), 0);   // Exactly one ack cycle
    endtask

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_dat_w = '0;
        cpu_sel   = '0;
        mem_ack   = 1'b0;
        mem_dat_r = '0;
        stim_lfsr = SEED;
        resp_lfsr = SEED;
        resp_busy = 1'b0;
        resp_wait = 0;
        cycle_cnt = 0;
        for (int i = 0; i < 65536; i++) begin
            model_mem[i] = init_byte(addr_t'(i));
            bus_mem[i]   = model_mem[i];
        end
        for (int s = 0; s < `CACHE_SETS; s++) begin
            sh_lru[s] = 1'b0;
            for (int i = 0; i < 2; i++) begin
                sh_tag[i][s]   = '0;
                sh_valid[i][s] = 1'b0;
                sh_dirty[i][s] = 1'b0;
            end
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;                             // Reset held for 2 cycles
        @(posedge clk);
        for (int n = 0; n < NUM_OPS; n++)
            run_op();
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* verilog/cache.sv */
module cache import cache_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,

    // CPU bus
    input  logic      cpu_cyc,
    input  logic      cpu_stb,
    input  logic      cpu_we,
    input  addr_t     cpu_adr,
    input  word_t     cpu_dat_w,
    input  byte_sel_t cpu_sel,
    output word_t     cpu_dat_r,
    output logic      cpu_ack,

    // Memory bus
    output logic      mem_cyc,
    output logic      mem_stb,
    output logic      mem_we,
    output addr_t     mem_adr,
    output line_t     mem_dat_w,
    input  line_t     mem_dat_r,
    input  logic      mem_ack
);

    // cpu_port <-> rest
    logic      req_valid, req_write, req_done;
    addr_t     req_adr;
    word_t     req_wdata;
    byte_sel_t req_sel;

    // control <-> datapath
    logic way_sel, tag_source_sel, load_word, load_line, load_lru;
    logic hit, dirty_out, lru_out;

    // control/datapath <-> mem_port
    logic  mem_read, mem_write, mem_done;
    addr_t mem_line_adr;
    line_t line_out, fill_line;

    cpu_port u_cpu_port (.*);             // Input side

    cache_control u_cache_control (.*);   // FSM

    cache_datapath u_cache_datapath (.*); // Arrays and hit logic

    mem_port u_mem_port (.*);             // Output side

endmodule

/* verilog/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// ******************************
// Address and data sizes
// ******************************
`define CACHE_ADDR_W    16              // CPU byte address
`define CACHE_WORD_W    16              // CPU data word
`define CACHE_LINE_W    128             // One cache line, one memory beat

// ******************************
// Organization
// ******************************
`define CACHE_SETS      8
`define CACHE_WAYS      2               // Two-way, one LRU bit per set
`define CACHE_INDEX_W   3               // log2 of CACHE_SETS
`define CACHE_OFFSET_W  4               // Byte offset inside a line
`define CACHE_TAG_W     9               // ADDR_W - INDEX_W - OFFSET_W

`endif

/* verilog/cache_control.sv */
module cache_control import cache_pkg::*; (
    input  logic clk,
    input  logic arst_n,

    // From cpu_port
    input  logic req_valid,
    input  logic req_write,
    output logic req_done,

    // Datapath handshake
    input  logic hit,
    input  logic dirty_out,
    input  logic lru_out,
    output logic way_sel,
    output logic tag_source_sel,
    output logic load_word,
    output logic load_line,
    output logic load_lru,

    // mem_port handshake
    output logic mem_read,
    output logic mem_write,
    input  logic mem_done
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        victim_q;              // Way being replaced on a miss

    // ******************************
    // State register
    // ******************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            victim_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == COMPARE && !hit)
                victim_q <= lru_out;    // Fixed for the rest of the miss
        end
    end

    // LRU way while comparing and the latched victim afterwards
    assign way_sel        = (state == COMPARE) ? lru_out : victim_q;
    assign tag_source_sel = (state == WRITE_BACK);
    assign mem_write      = (state == WRITE_BACK);  // Held until mem_done
    assign mem_read       = (state == FILL);

    // ******************************
    // Next state and strobes
    // ******************************
    always_comb begin
        state_nxt = state;
        req_done  = 1'b0;
        load_word = 1'b0;
        load_line = 1'b0;
        load_lru  = 1'b0;
        case (state)
            IDLE: begin
                if (req_valid)
                    state_nxt = COMPARE;
            end
            COMPARE: begin
                if (hit) begin
                    req_done  = 1'b1;       // cpu_ack follows next cycle
                    load_lru  = 1'b1;
                    load_word = req_write;
                    state_nxt = RESPOND;
                end else if (dirty_out) begin
                    state_nxt = WRITE_BACK;
                end else begin
                    state_nxt = FILL;       // Clean victim is simply overwritten
                end
            end
            WRITE_BACK: begin
                if (mem_done)
                    state_nxt = FILL;
            end
            FILL: begin
                if (mem_done) begin
                    load_line = 1'b1;       // fill_line is valid with mem_done
                    state_nxt = COMPARE;    // Lookup again and hit this time
                end
            end
            RESPOND: begin
                state_nxt = IDLE;
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    // A done pulse only comes back while exactly one transfer is requested
    a_done_while_waiting: assert property (@(posedge clk) disable iff (!arst_n)
        mem_done |-> (mem_read ^ mem_write));

endmodule

/* verilog/cache_datapath.sv */
`include "cache_config.svh"

module cache_datapath import cache_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,

    // Request from cpu_port
    input  addr_t     req_adr,
    input  word_t     req_wdata,
    input  byte_sel_t req_sel,

    // Control
    input  logic      way_sel,          // Victim way for line ops
    input  logic      tag_source_sel,   // 1: victim tag, 0: request tag
    input  logic      load_word,
    input  logic      load_line,
    input  logic      load_lru,
    output logic      hit,
    output logic      dirty_out,
    output logic      lru_out,

    // CPU read data
    output word_t     cpu_dat_r,

    // Memory side
    output addr_t     mem_line_adr,
    output line_t     line_out,
    input  line_t     fill_line
);

    // ******************************
    // Arrays
    // ******************************
    tag_t  tag_arr   [`CACHE_WAYS][`CACHE_SETS];
    line_t line_arr  [`CACHE_WAYS][`CACHE_SETS];
    logic  valid_arr [`CACHE_WAYS][`CACHE_SETS];
    logic  dirty_arr [`CACHE_WAYS][`CACHE_SETS];
    logic  lru_arr   [`CACHE_SETS];    // Points at the way to replace next

    tag_t                       req_tag;
    index_t                     req_index;
    logic [`CACHE_OFFSET_W-2:0] word_off;  // Word inside the line
    logic                       hit_0;
    logic                       hit_1;
    logic                       hit_way;
    line_t                      hit_line;
    line_t                      merged_line;
    tag_t                       line_tag;

    // Address split: tag | index | offset
    assign req_tag   = req_adr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    assign req_index = req_adr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
    assign word_off  = req_adr[`CACHE_OFFSET_W-1:1];   // Bit 0 is the byte lane

    // ******************************
    // Lookup
    // ******************************
    assign hit_0   = valid_arr[0][req_index] && (tag_arr[0][req_index] == req_tag);
    assign hit_1   = valid_arr[1][req_index] && (tag_arr[1][req_index] == req_tag);
    assign hit     = hit_0 || hit_1;
    assign hit_way = hit_1;                              // Way 0 unless way 1 hits

    assign hit_line  = line_arr[hit_way][req_index];
    assign cpu_dat_r = hit_line[word_off*`CACHE_WORD_W +: `CACHE_WORD_W];

    assign lru_out   = lru_arr[req_index];
    assign dirty_out = dirty_arr[way_sel][req_index];    // Dirty bit of the victim
    assign line_out  = line_arr[way_sel][req_index];

    // Write-back uses the stored tag, fill uses the request tag
    assign line_tag     = tag_source_sel ? tag_arr[way_sel][req_index] : req_tag;
    assign mem_line_adr = {line_tag, req_index, {`CACHE_OFFSET_W{1'b0}}};

    // Byte merge of the write word into the hit line
    always_comb begin
        merged_line = hit_line;
        for (int b = 0; b < `CACHE_WORD_W/8; b++) begin
            if (req_sel[b])
                merged_line[word_off*`CACHE_WORD_W + b*8 +: 8] = req_wdata[b*8 +: 8];
        end
    end

    // ******************************
    // Line and tag storage
    // ******************************
    always_ff @(posedge clk) begin
        if (load_line) begin
            line_arr[way_sel][req_index] <= fill_line;
            tag_arr[way_sel][req_index]  <= req_tag;
        end else if (load_word) begin
            line_arr[hit_way][req_index] <= merged_line;   // Write hit
        end
    end

    // Status bits, cleared by reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                lru_arr[s] <= 1'b0;
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    valid_arr[w][s] <= 1'b0;
                    dirty_arr[w][s] <= 1'b0;
                end
            end
        end else begin
            if (load_line) begin
                valid_arr[way_sel][req_index] <= 1'b1;
                dirty_arr[way_sel][req_index] <= 1'b0;     // Fresh from memory
            end else if (load_word) begin
                dirty_arr[hit_way][req_index] <= 1'b1;
            end
            if (load_lru)
                lru_arr[req_index] <= ~hit_way;            // Other way becomes LRU
        end
    end

    // A tag lives in at most one way of a set
    a_one_way_hits: assert property (@(posedge clk) disable iff (!arst_n)
        !(hit_0 && hit_1));

endmodule

/* verilog/cache_pkg.sv */
package cache_pkg;

`include "cache_config.svh"

    // ******************************
    // Width types
    // ******************************
    typedef logic [`CACHE_ADDR_W-1:0]   addr_t;       // Byte address
    typedef logic [`CACHE_WORD_W-1:0]   word_t;       // CPU word
    typedef logic [`CACHE_WORD_W/8-1:0] byte_sel_t;   // One enable per byte
    typedef logic [`CACHE_LINE_W-1:0]   line_t;       // Whole line
    typedef logic [`CACHE_TAG_W-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]  index_t;

    // ******************************
    // Controller states
    // ******************************
    typedef enum logic [2:0] {
        IDLE,           // Wait for a captured request
        COMPARE,        // Tag lookup
        WRITE_BACK,     // Dirty victim goes out to memory
        FILL,           // Missing line comes in
        RESPOND         // Ack cycle on the CPU bus
    } ctrl_state_t;

endpackage

/* verilog/cpu_port.sv */
module cpu_port import cache_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,

    // CPU bus, slave side
    input  logic      cpu_cyc,
    input  logic      cpu_stb,
    input  logic      cpu_we,
    input  addr_t     cpu_adr,
    input  word_t     cpu_dat_w,
    input  byte_sel_t cpu_sel,
    output logic      cpu_ack,

    // Held request towards the cache
    output logic      req_valid,
    output logic      req_write,
    output addr_t     req_adr,
    output word_t     req_wdata,
    output byte_sel_t req_sel,
    input  logic      req_done
);

    logic capture;

    // Idle means no request held and no ack going out
    assign capture = cpu_cyc && cpu_stb && !req_valid && !cpu_ack;

    // Handshake state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_valid <= 1'b0;
            cpu_ack   <= 1'b0;
        end else begin
            cpu_ack <= req_done;                // One cycle after the cache finishes
            if (capture)
                req_valid <= 1'b1;
            else if (req_done)
                req_valid <= 1'b0;              // Free again in the ack cycle
        end
    end

    // Request payload, held until done
    always_ff @(posedge clk) begin
        if (capture) begin
            req_write <= cpu_we;
            req_adr   <= cpu_adr;
            req_wdata <= cpu_dat_w;
            req_sel   <= cpu_sel;
        end
    end

    // CPU must keep the same request on the bus while we work on it
    a_cpu_holds: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> (cpu_cyc && cpu_stb && cpu_adr == req_adr && cpu_we == req_write));

endmodule

/* verilog/mem_port.sv */
`include "cache_config.svh"

module mem_port import cache_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,

    // From control and datapath
    input  logic  mem_read,
    input  logic  mem_write,
    input  addr_t mem_line_adr,
    input  line_t line_out,
    output logic  mem_done,             // One-cycle pulse
    output line_t fill_line,

    // Master side of the memory bus
    output logic  mem_cyc,
    output logic  mem_stb,
    output logic  mem_we,
    output addr_t mem_adr,
    output line_t mem_dat_w,
    input  logic  mem_ack,
    input  line_t mem_dat_r
);

    logic start;

    // New cycle only when bus is free and the last done has been seen
    assign start = (mem_read || mem_write) && !mem_cyc && !mem_done;

    // Bus control
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_cyc  <= 1'b0;
            mem_stb  <= 1'b0;
            mem_we   <= 1'b0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= mem_cyc && mem_ack;
            if (start) begin
                mem_cyc <= 1'b1;
                mem_stb <= 1'b1;
                mem_we  <= mem_write;
            end else if (mem_cyc && mem_ack) begin
                mem_cyc <= 1'b0;            // Single beat ends the cycle
                mem_stb <= 1'b0;
                mem_we  <= 1'b0;
            end
        end
    end

    // Address and data frozen for the whole bus cycle
    always_ff @(posedge clk) begin
        if (start) begin
            mem_adr   <= mem_line_adr;
            mem_dat_w <= line_out;
        end
        if (mem_cyc && mem_ack && !mem_we)
            fill_line <= mem_dat_r;         // Read data for the fill
    end

    a_adr_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        mem_stb |-> (mem_adr[`CACHE_OFFSET_W-1:0] == '0));

    // Control keeps the same request up for the whole bus cycle
    a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        mem_cyc |-> (mem_we ? mem_write : mem_read));

endmodule
